// File: all.f
+incdir+verif
hdl/gsm_shaper_pkg.sv
hdl/sample_strobe_gen.sv
hdl/symbol_hold_mapper.sv
hdl/gauss_coeff_rom.sv
hdl/folded_fir_timeshared.sv
hdl/gsm_pulse_shaper_top.sv
verif/tb_gsm_pulse_shaper.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with verilator, the log decides the result
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/10ps -f all.f \
    --top-module tb_gsm_pulse_shaper -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verif/fir_golden_model.svh
`ifndef FIR_GOLDEN_MODEL_SVH
`define FIR_GOLDEN_MODEL_SVH

// half gaussian response in 0s18, entry 0 is the outer tap, entry 50 the centre
localparam int ref_taps [51] = '{
    73, -7, -89, -99, -22, 87, 137, 76, -60, -167,
    -153, -12, 156, 219, 116, -87, -235, -205, -9, 201,
    251, 84, -173, -297, -149, 184, 426, 320, -141, -639,
    -731, -198, 705, 1329, 1057, -178, -1686, -2348, -1369, 1014,
    3408, 3971, 1626, -2912, -7056, -7450, -1796, 9590, 23440, 34770,
    39137
};

// nrz level for one bit
function automatic logic signed [17:0] map_bit(input logic b, input logic signed [17:0] amp);
    return b ? amp : -amp;
endfunction

// bit exact filter output, window[0] is the newest sample
function automatic logic signed [17:0] filter_output(input logic signed [17:0] window [taps]);
    logic signed [17:0] half [taps];
    logic signed [17:0] pair;
    logic signed [17:0] coeff;
    logic signed [35:0] prod;
    logic signed [17:0] total;
    total = '0;
    for (int i = 0; i < taps; i++) begin
        half[i] = window[i] >>> 1;
    end
    for (int i = 0; i < pairs; i++) begin
        // pair sum wraps at 18 bits, centre tap stands alone
        pair = (i == pairs - 1) ? half[i] : half[i] + half[taps - 1 - i];
        coeff = 18'(ref_taps[i]);
        prod = pair * coeff;
        total = total + prod[34:17];
    end
    return total;
endfunction

// steady state output for a constant input level
function automatic logic signed [17:0] dc_level(input logic signed [17:0] level);
    logic signed [17:0] window [taps];
    for (int i = 0; i < taps; i++) begin
        window[i] = level;
    end
    return filter_output(window);
endfunction

`endif

// File: verif/tb_gsm_pulse_shaper.sv
`timescale 1ns/10ps
`default_nettype none

module tb_gsm_pulse_shaper;

    localparam int spsym = 4;
    localparam logic signed [17:0] amplitude = 18'sd65536;
    localparam int taps = gsm_shaper_pkg::filter_length;
    localparam int pairs = gsm_shaper_pkg::fold_count;
    localparam int req_spacing = spsym * gsm_shaper_pkg::clks_per_sample;
    localparam int timeout_cycles = 64;
    localparam int num_tests = 5;

    typedef enum int {mode_one, mode_zero, mode_single, mode_alt, mode_random} mode_t;

    // stimulus table whose rows run back to back without reset
    string test_name [num_tests] = '{
        "const_one", "const_zero", "single_one", "alternating", "random"
    };
    mode_t test_mode [num_tests] = '{mode_one, mode_zero, mode_single, mode_alt, mode_random};
    int    test_syms [num_tests] = '{32, 32, 40, 40, 64};

    logic sys_clk;
    logic reset;
    logic bit_in;
    wire  bit_req;
    wire  signed [17:0] sample_out;
    wire  sample_valid;

    int    seed;
    int    row;
    int    sym_idx;
    int    cycle_count;
    int    last_req_cycle;
    int    check_count;
    int    error_count;
    int    test_errors;
    bit    timed_out;
    bit    pending;
    string current_test;
    logic  last_bit;
    logic signed [17:0] pending_level;
    logic signed [17:0] held_level;
    logic signed [17:0] last_sample;
    logic signed [17:0] x_history [$];

    `include "fir_golden_model.svh"

    gsm_pulse_shaper_top #(
        .samples_per_symbol (spsym),
        .symbol_amplitude   (amplitude)
    ) u_gsm_pulse_shaper_top (
        .sys_clk      (sys_clk),
        .reset        (reset),
        .bit_in       (bit_in),
        .bit_req      (bit_req),
        .sample_out   (sample_out),
        .sample_valid (sample_valid)
    );

    always #10 sys_clk = ~sys_clk;

    task automatic check_value(input string what, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("[FAIL] %0t %s %s: expected %0d, got %0d",
                     $time, current_test, what, expected, actual);
        end
    endtask

    function automatic logic next_bit(input mode_t mode, input int idx);
        case (mode)
            mode_one:    return 1'b1;
            mode_zero:   return 1'b0;
            mode_single: return idx == 8;
            mode_alt:    return idx[0];
            default:     return 1'($random(seed));
        endcase
    endfunction

    // one clock step with outputs sampled and inputs driven 1 ns after the edge
    task automatic step_cycle(output bit req_seen, output bit valid_seen);
        logic signed [17:0] window [taps];
        int k;
        logic b;
        @(posedge sys_clk);
        #1;
        cycle_count++;
        req_seen = bit_req;
        valid_seen = sample_valid;
        if (sample_valid) begin
            // the held level entered the delay line at the last strobe
            x_history.push_back(held_level);
            if (pending) begin
                held_level = pending_level;
                pending = 1'b0;
            end
            // output belongs to the input three sample periods back
            k = x_history.size() - 4;
            for (int i = 0; i < taps; i++) begin
                window[i] = (k - i >= 0) ? x_history[k - i] : '0;
            end
            check_value("sample_out", filter_output(window), sample_out);
            last_sample = sample_out;
        end else begin
            // output register only moves on the strobe
            check_value("sample_out hold", last_sample, sample_out);
        end
        if (bit_req) begin
            if (last_req_cycle > 0) begin
                check_value("bit_req spacing", req_spacing, cycle_count - last_req_cycle);
            end
            last_req_cycle = cycle_count;
            b = next_bit(test_mode[row], sym_idx);
            sym_idx++;
            bit_in = b;
            last_bit = b;
            pending = 1'b1;
            pending_level = map_bit(b, amplitude);
        end else begin
            // inverted bit between requests
            bit_in = ~last_bit;
        end
    endtask

    task automatic wait_for_event(input bit want_req, input string what);
        bit req;
        bit valid;
        bit seen;
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < timeout_cycles) begin
            step_cycle(req, valid);
            seen = want_req ? req : valid;
            n++;
        end
        if (!seen) begin
            $display("timeout: no %s within %0d cycles in test %s", what, timeout_cycles,
                     current_test);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        seed = 32'hd630;
        sys_clk = 1'b0;
        reset = 1'b1;
        bit_in = 1'b0;
        last_bit = 1'b0;
        row = 0;
        sym_idx = 0;
        cycle_count = 0;
        last_req_cycle = 0;
        check_count = 0;
        error_count = 0;
        timed_out = 1'b0;
        pending = 1'b0;
        held_level = '0;
        last_sample = '0;
        repeat (3) @(posedge sys_clk);
        #1;
        reset = 1'b0;

        current_test = "reset";
        test_errors = 0;
        check_value("sample_out after reset", 0, sample_out);
        check_value("sample_valid after reset", 0, sample_valid);
        wait_for_event(1'b0, "first sample_valid");
        $display("test %s done: %0d mismatches", current_test, test_errors);

        for (int r = 0; r < num_tests && !timed_out; r++) begin
            row = r;
            sym_idx = 0;
            current_test = test_name[r];
            test_errors = 0;
            while (sym_idx < test_syms[r] && !timed_out) begin
                wait_for_event(1'b1, "bit_req");
            end
            // delay line full of one level by now
            if (test_mode[r] == mode_one && !timed_out) begin
                check_value("dc level", dc_level(amplitude), last_sample);
            end else if (test_mode[r] == mode_zero && !timed_out) begin
                check_value("dc level", dc_level(-amplitude), last_sample);
            end
            $display("test %s done: %0d mismatches", current_test, test_errors);
        end

        // drain the samples still in the pipeline
        for (int i = 0; i < 4 && !timed_out; i++) begin
            wait_for_event(1'b0, "sample_valid");
        end

        $display("checks %0d, mismatches %0d, timeout %0d", check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/gsm_pulse_shaper_top.sv
`timescale 1ns/10ps
`default_nettype none

module gsm_pulse_shaper_top #(
    parameter int samples_per_symbol = 4,
    parameter logic signed [gsm_shaper_pkg::sample_width-1:0] symbol_amplitude = 18'sd65536
) (
    input  wire  sys_clk,
    input  wire  reset,
    input  wire  bit_in,
    output logic bit_req,
    output logic signed [gsm_shaper_pkg::sample_width-1:0] sample_out,
    output logic sample_valid
);

    logic                                          sam_clk_en;
    logic signed [gsm_shaper_pkg::sample_width-1:0] x_in;

    // one sample every four clocks
    sample_strobe_gen u_sample_strobe_gen (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .sam_clk_en (sam_clk_en)
    );

    // nrz symbol stream
    symbol_hold_mapper #(
        .samples_per_symbol (samples_per_symbol),
        .symbol_amplitude   (symbol_amplitude)
    ) u_symbol_hold_mapper (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .sam_clk_en (sam_clk_en),
        .bit_in     (bit_in),
        .bit_req    (bit_req),
        .x_in       (x_in)
    );

    // gaussian shaping filter
    folded_fir_timeshared u_folded_fir_timeshared (
        .sys_clk      (sys_clk),
        .reset        (reset),
        .sam_clk_en   (sam_clk_en),
        .x_in         (x_in),
        .sample_out   (sample_out),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

// File: hdl/folded_fir_timeshared.sv
`timescale 1ns/10ps
`default_nettype none

module folded_fir_timeshared (
    input  wire  sys_clk,
    input  wire  reset,
    input  wire  sam_clk_en,
    input  wire  signed [gsm_shaper_pkg::sample_width-1:0] x_in,
    output logic signed [gsm_shaper_pkg::sample_width-1:0] sample_out,
    output logic sample_valid
);

    localparam int width      = gsm_shaper_pkg::sample_width;
    localparam int pwidth     = gsm_shaper_pkg::product_width;
    localparam int taps       = gsm_shaper_pkg::filter_length;
    localparam int pairs      = gsm_shaper_pkg::fold_count;
    localparam int lanes      = gsm_shaper_pkg::mult_lanes;
    localparam int shift      = gsm_shaper_pkg::product_shift;
    localparam int phw        = gsm_shaper_pkg::phase_width;
    localparam int lvl2_count = (lanes + 1) / 2;
    localparam int lvl3_count = (lvl2_count + 1) / 2;
    localparam int lvl4_count = lvl3_count / 2;

    // registered tree levels before the final combinational add
    localparam int tree_latency = 3;

    localparam logic [phw-1:0] last_phase = phw'(gsm_shaper_pkg::clks_per_sample - 1);
    localparam logic [phw-1:0] acc_load_phase =
        phw'(tree_latency % gsm_shaper_pkg::clks_per_sample);

    logic signed [width-1:0]  delay_line [taps];
    logic signed [width-1:0]  fold_sum [pairs];
    logic [phw-1:0]           phase;
    logic [lanes-1:0][width-1:0] coeff_lanes;
    logic signed [width-1:0]  mult_in [lanes];
    logic signed [pwidth-1:0] product [lanes];
    logic signed [width-1:0]  product_slice [lanes];
    logic signed [width-1:0]  lvl2_sum [lvl2_count];
    logic signed [width-1:0]  lvl3_sum [lvl3_count];
    logic signed [width-1:0]  lvl4_sum [lvl4_count];
    logic signed [width-1:0]  tree_sum;
    logic signed [width-1:0]  acc;

    // input scaled 1s17 to 2s16 so pair sums fit
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < taps; i++) begin
                delay_line[i] <= '0;
            end
        end else if (sam_clk_en) begin
            delay_line[0] <= x_in >>> 1;
            for (int i = 1; i < taps; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    // symmetric fold with the centre tap passed alone
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < pairs; i++) begin
                fold_sum[i] <= '0;
            end
        end else if (sam_clk_en) begin
            for (int i = 0; i < pairs - 1; i++) begin
                fold_sum[i] <= delay_line[i] + delay_line[taps-1-i];
            end
            fold_sum[pairs-1] <= delay_line[pairs-1];
        end
    end

    // reset value puts the first strobe on the last phase
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            phase <= last_phase;
        end else if (sam_clk_en) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    gauss_coeff_rom u_gauss_coeff_rom (
        .phase       (phase),
        .coeff_lanes (coeff_lanes)
    );

    // pair select uses the same lane mapping as the rom
    always_comb begin : pair_select
        int tap;
        for (int lane = 0; lane < lanes; lane++) begin
            tap = lane * gsm_shaper_pkg::clks_per_sample + int'(phase);
            if (tap < pairs) begin
                mult_in[lane] = fold_sum[tap];
            end else begin
                mult_in[lane] = '0;
            end
        end
    end

    // 2s16 data times 0s18 coeff sliced down to 1s17
    always_comb begin
        for (int lane = 0; lane < lanes; lane++) begin
            product[lane]       = mult_in[lane] * $signed(coeff_lanes[lane]);
            product_slice[lane] = product[lane][shift+width-1:shift];
        end
    end

    // three registered levels where odd entries pass through
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < lvl2_count; i++) begin
                lvl2_sum[i] <= '0;
            end
            for (int i = 0; i < lvl3_count; i++) begin
                lvl3_sum[i] <= '0;
            end
            for (int i = 0; i < lvl4_count; i++) begin
                lvl4_sum[i] <= '0;
            end
        end else begin
            for (int i = 0; i < lvl2_count - 1; i++) begin
                lvl2_sum[i] <= product_slice[2*i] + product_slice[2*i+1];
            end
            lvl2_sum[lvl2_count-1] <= product_slice[lanes-1];

            for (int i = 0; i < lvl3_count - 1; i++) begin
                lvl3_sum[i] <= lvl2_sum[2*i] + lvl2_sum[2*i+1];
            end
            lvl3_sum[lvl3_count-1] <= lvl2_sum[lvl2_count-1];

            for (int i = 0; i < lvl4_count; i++) begin
                lvl4_sum[i] <= lvl3_sum[2*i] + lvl3_sum[2*i+1];
            end
        end
    end

    assign tree_sum = lvl4_sum[0] + lvl4_sum[1];

    // phase 0 partial arrives after the tree latency and restarts the sum
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            acc <= '0;
        end else if (phase == acc_load_phase) begin
            acc <= tree_sum;
        end else begin
            acc <= acc + tree_sum;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            sample_out   <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= sam_clk_en;
            if (sam_clk_en) begin
                sample_out <= acc;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/gauss_coeff_rom.sv
`timescale 1ns/10ps
`default_nettype none

module gauss_coeff_rom (
    input  wire  [gsm_shaper_pkg::phase_width-1:0] phase,
    output logic [gsm_shaper_pkg::mult_lanes-1:0][gsm_shaper_pkg::sample_width-1:0] coeff_lanes
);

    // half filter in 0s18, index 0 is the outer tap, last is the centre
    localparam logic signed [gsm_shaper_pkg::sample_width-1:0]
        half_taps [gsm_shaper_pkg::fold_count] = '{
        18'sd73,
        -18'sd7,
        -18'sd89,
        -18'sd99,
        -18'sd22,
        18'sd87,
        18'sd137,
        18'sd76,
        -18'sd60,
        -18'sd167,
        -18'sd153,
        -18'sd12,
        18'sd156,
        18'sd219,
        18'sd116,
        -18'sd87,
        -18'sd235,
        -18'sd205,
        -18'sd9,
        18'sd201,
        18'sd251,
        18'sd84,
        -18'sd173,
        -18'sd297,
        -18'sd149,
        18'sd184,
        18'sd426,
        18'sd320,
        -18'sd141,
        -18'sd639,
        -18'sd731,
        -18'sd198,
        18'sd705,
        18'sd1329,
        18'sd1057,
        -18'sd178,
        -18'sd1686,
        -18'sd2348,
        -18'sd1369,
        18'sd1014,
        18'sd3408,
        18'sd3971,
        18'sd1626,
        -18'sd2912,
        -18'sd7056,
        -18'sd7450,
        -18'sd1796,
        18'sd9590,
        18'sd23440,
        18'sd34770,
        18'sd39137
    };

    // lane i reads tap 4i + phase, past the centre reads zero
    always_comb begin : lane_select
        int tap;
        for (int lane = 0; lane < gsm_shaper_pkg::mult_lanes; lane++) begin
            tap = lane * gsm_shaper_pkg::clks_per_sample + int'(phase);
            if (tap < gsm_shaper_pkg::fold_count) begin
                coeff_lanes[lane] = half_taps[tap];
            end else begin
                coeff_lanes[lane] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/symbol_hold_mapper.sv
`timescale 1ns/10ps
`default_nettype none

module symbol_hold_mapper #(
    parameter int samples_per_symbol = 4,
    parameter logic signed [gsm_shaper_pkg::sample_width-1:0] symbol_amplitude = 18'sd65536
) (
    input  wire  sys_clk,
    input  wire  reset,
    input  wire  sam_clk_en,
    input  wire  bit_in,
    output logic bit_req,
    output logic signed [gsm_shaper_pkg::sample_width-1:0] x_in
);

    localparam int count_width =
        (samples_per_symbol > 1) ? $clog2(samples_per_symbol) : 1;
    localparam logic [count_width-1:0] last_count = count_width'(samples_per_symbol - 1);

    logic [count_width-1:0] hold_cnt;
    logic                   symbol_start;

    // counter at zero means the next strobe opens a symbol
    assign symbol_start = (hold_cnt == '0);
    assign bit_req      = sam_clk_en && symbol_start;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            hold_cnt <= '0;
            x_in     <= '0;
        end else if (sam_clk_en) begin
            if (hold_cnt == last_count) begin
                hold_cnt <= '0;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
            // nrz mapping, level held until the next symbol
            if (symbol_start) begin
                x_in <= bit_in ? symbol_amplitude : -symbol_amplitude;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/sample_strobe_gen.sv
`timescale 1ns/10ps
`default_nettype none

module sample_strobe_gen (
    input  wire  sys_clk,
    input  wire  reset,
    output logic sam_clk_en
);

    localparam logic [gsm_shaper_pkg::phase_width-1:0] terminal_count =
        gsm_shaper_pkg::phase_width'(gsm_shaper_pkg::clks_per_sample - 1);

    logic [gsm_shaper_pkg::phase_width-1:0] clk_cnt;

    // free running divider, strobe registered on terminal count
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            clk_cnt    <= '0;
            sam_clk_en <= 1'b0;
        end else begin
            clk_cnt    <= clk_cnt + 1'b1;
            sam_clk_en <= (clk_cnt == terminal_count);
        end
    end

endmodule

`default_nettype wire

// File: hdl/gsm_shaper_pkg.sv
`default_nettype none

package gsm_shaper_pkg;

    // sample, coefficient and partial sum width
    localparam int sample_width = 18;

    // full 2s34 multiplier result
    localparam int product_width = 36;

    // symmetric gaussian filter
    localparam int filter_length = 101;

    // folded pairs, centre tap included
    localparam int fold_count = 51;

    // shared multipliers, each serves one tap per phase
    localparam int mult_lanes = 13;

    // clocks per output sample
    // lane i serves fold pair i*clks_per_sample + phase
    localparam int clks_per_sample = 4;

    // product slice starts here, bits 34..17 give 1s17
    localparam int product_shift = 17;

    // phase counter width
    localparam int phase_width = 2;

endpackage

`default_nettype wire
